/* project.f */
rtl/lsu_pkg.sv
rtl/lsu_op_if.sv
rtl/lsu_store_lanes.sv
rtl/lsu_load_lanes.sv
rtl/lsu_access_ctrl.sv
rtl/lsu_top.sv
verif/lsu_sva.sv
verif/lsu_tb.sv

/* rtl/lsu_access_ctrl.sv */
// Load/store access controller

`timescale 1ns/1ps

module lsu_access_ctrl (
  input  logic                            clk,
  input  logic                            rst,

  input  logic                            in_valid,
  output logic                            in_ready,
  input  lsu_pkg::word_t                  in_pc,
  input  logic [2:0]                      in_funct3,
  input  logic                            in_store,
  input  lsu_pkg::word_t                  in_rs1_data,
  input  lsu_pkg::word_t                  in_rs2_data,
  input  logic [lsu_pkg::imm_w-1:0]       in_imm,
  input  lsu_pkg::reg_idx_t               in_rd,

  output logic                            bus_req,
  input  logic                            bus_ack,
  output logic                            bus_write,
  output lsu_pkg::word_t                  bus_addr,
  output lsu_pkg::lane_mask_t             bus_rd_mask,
  output lsu_pkg::lane_mask_t             bus_wr_mask,
  output lsu_pkg::word_t                  bus_wr_data,

  output logic                            out_valid,
  input  logic                            out_ready,
  output logic                            out_trap,
  output logic                            out_rd_wr,
  output lsu_pkg::reg_idx_t               out_rd,
  output lsu_pkg::word_t                  out_rd_data,
  output lsu_pkg::word_t                  out_pc_next,

  input  lsu_pkg::lane_mask_t             lane_mask,
  input  lsu_pkg::word_t                  wr_data,
  input  lsu_pkg::word_t                  load_data,

  lsu_op_if.ctrl                          op
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_respond
  } state_e;

  state_e           state;
  lsu_pkg::lsu_op_e dec_kind;
  lsu_pkg::lsu_op_e kind_q;
  lsu_pkg::word_t   eff_addr;
  lsu_pkg::word_t   addr_q;
  lsu_pkg::word_t   data_q;
  logic             capture;
  logic             trap_now;
  logic             is_store;
  logic             is_load;

  // stores only exist for the three signed widths
  always_comb
  begin
    case (in_funct3)
      lsu_pkg::f3_byte:   dec_kind = in_store ? lsu_pkg::op_sb : lsu_pkg::op_lb;
      lsu_pkg::f3_half:   dec_kind = in_store ? lsu_pkg::op_sh : lsu_pkg::op_lh;
      lsu_pkg::f3_word:   dec_kind = in_store ? lsu_pkg::op_sw : lsu_pkg::op_lw;
      lsu_pkg::f3_byte_u: dec_kind = in_store ? lsu_pkg::op_bad : lsu_pkg::op_lbu;
      lsu_pkg::f3_half_u: dec_kind = in_store ? lsu_pkg::op_bad : lsu_pkg::op_lhu;
      default:            dec_kind = lsu_pkg::op_bad;
    endcase
  end

  assign eff_addr = in_rs1_data
                  + {{(lsu_pkg::xlen-lsu_pkg::imm_w){in_imm[lsu_pkg::imm_w-1]}}, in_imm};

  // an illegal op or a misaligned PC never reaches the bus
  assign trap_now = (dec_kind == lsu_pkg::op_bad) || (in_pc[1:0] != 2'b00);

  assign in_ready = (state == st_idle);
  assign capture  = in_valid && in_ready;

  assign is_store = (kind_q inside {lsu_pkg::op_sb, lsu_pkg::op_sh, lsu_pkg::op_sw});
  assign is_load  = (kind_q inside {lsu_pkg::op_lb, lsu_pkg::op_lh, lsu_pkg::op_lw,
                                    lsu_pkg::op_lbu, lsu_pkg::op_lhu});

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= st_idle;
      out_trap  <= 1'b0;
      out_rd_wr <= 1'b0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (capture)
          begin
            state     <= trap_now ? st_respond : st_request;
            out_trap  <= trap_now;
            out_rd_wr <= 1'b0;
          end
        end
        st_request:
        begin
          if (bus_ack)
          begin
            state     <= st_respond;
            out_rd_wr <= is_load;
          end
        end
        st_respond:
        begin
          if (out_ready)
          begin
            state     <= st_idle;
            out_trap  <= 1'b0;
            out_rd_wr <= 1'b0;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // operation and result payload
  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      kind_q      <= dec_kind;
      addr_q      <= eff_addr;
      data_q      <= in_rs2_data;
      out_rd      <= in_rd;
      out_pc_next <= in_pc + lsu_pkg::pc_step;
      out_rd_data <= '0;
    end
    else if ((state == st_request) && bus_ack)
    begin
      // x0 always reads back as zero
      out_rd_data <= (out_rd == '0) ? '0 : load_data;
    end
  end

  assign op.kind       = kind_q;
  assign op.addr       = addr_q;
  assign op.store_data = data_q;
  assign op.held       = (state != st_idle);

  // request fields come straight from held registers, so they stay stable
  assign bus_req     = (state == st_request);
  assign bus_write   = is_store;
  assign bus_addr    = {addr_q[lsu_pkg::xlen-1:2], 2'b00};
  assign bus_rd_mask = is_store ? '0 : lane_mask;
  assign bus_wr_mask = is_store ? lane_mask : '0;
  assign bus_wr_data = wr_data;

  assign out_valid = (state == st_respond);

endmodule

/* rtl/lsu_load_lanes.sv */
// Load lane extractor

`timescale 1ns/1ps

module lsu_load_lanes (
  lsu_op_if.lanes           op,
  input  lsu_pkg::word_t    rd_word,
  output lsu_pkg::word_t    load_data
);

  lsu_pkg::mem_word_u rd_view;
  logic [7:0]         sel_byte;
  logic [15:0]        sel_half;

  assign rd_view = rd_word;

  // lane picked by the low address bits of the held operation
  assign sel_byte = rd_view.bytes[op.addr[1:0]];
  assign sel_half = rd_view.halves[op.addr[1]];

  always_comb
  begin
    load_data = '0;
    if (op.held)
    begin
      case (op.kind)
        lsu_pkg::op_lb:
        begin
          load_data = {{(lsu_pkg::xlen-8){sel_byte[7]}}, sel_byte};
        end
        lsu_pkg::op_lbu:
        begin
          load_data = {{(lsu_pkg::xlen-8){1'b0}}, sel_byte};
        end
        lsu_pkg::op_lh:
        begin
          load_data = {{(lsu_pkg::xlen-16){sel_half[15]}}, sel_half};
        end
        lsu_pkg::op_lhu:
        begin
          load_data = {{(lsu_pkg::xlen-16){1'b0}}, sel_half};
        end
        lsu_pkg::op_lw:
        begin
          load_data = rd_view;
        end
        // stores and traps return nothing to the register file
        default:
        begin
          load_data = '0;
        end
      endcase
    end
  end

endmodule

/* rtl/lsu_op_if.sv */
// Held memory operation

`timescale 1ns/1ps

interface lsu_op_if;

  // decoded kind of the operation in flight
  lsu_pkg::lsu_op_e kind;

  // full effective address, low bits still present for lane selection
  lsu_pkg::word_t addr;

  // rs2 value as captured, before lane placement
  lsu_pkg::word_t store_data;

  // high from capture until the result has been taken
  logic held;

  modport ctrl (
    output kind,
    output addr,
    output store_data,
    output held
  );

  modport lanes (
    input kind,
    input addr,
    input store_data,
    input held
  );

endinterface

/* rtl/lsu_pkg.sv */
// Load/store unit definitions

package lsu_pkg;

  // the ISA fixes these widths
  localparam int xlen      = 32;
  localparam int num_lanes = 4;
  localparam int imm_w     = 12;
  localparam int reg_idx_w = 5;
  localparam int pc_step   = 4;

  typedef logic [xlen-1:0]      word_t;
  typedef logic [num_lanes-1:0] lane_mask_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;

  // funct3 width and signedness codes for loads and stores
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // decoded memory operation, op_bad marks an illegal funct3 and store pair
  typedef enum logic [3:0] {
    op_lb,
    op_lh,
    op_lw,
    op_lbu,
    op_lhu,
    op_sb,
    op_sh,
    op_sw,
    op_bad
  } lsu_op_e;

  // one bus word, seen either as byte lanes or as halfword lanes
  typedef union packed {
    logic [num_lanes-1:0][7:0]     bytes;
    logic [num_lanes/2-1:0][15:0]  halves;
  } mem_word_u;

endpackage

/* rtl/lsu_store_lanes.sv */
// Store lane mapper

`timescale 1ns/1ps

module lsu_store_lanes (
  lsu_op_if.lanes                  op,
  output lsu_pkg::lane_mask_t      lane_mask,
  output lsu_pkg::word_t           wr_data
);

  lsu_pkg::mem_word_u wr_word;
  logic [1:0]         offset;

  assign offset = op.addr[1:0];

  // byte lanes touched by the access, used for loads and stores alike
  always_comb
  begin
    lane_mask = '0;
    if (op.held)
    begin
      case (op.kind)
        lsu_pkg::op_lb, lsu_pkg::op_lbu, lsu_pkg::op_sb:
        begin
          lane_mask = lsu_pkg::lane_mask_t'(1) << offset;
        end
        lsu_pkg::op_lh, lsu_pkg::op_lhu, lsu_pkg::op_sh:
        begin
          lane_mask = offset[1] ? 4'b1100 : 4'b0011;
        end
        lsu_pkg::op_lw, lsu_pkg::op_sw:
        begin
          lane_mask = '1;
        end
        default:
        begin
          lane_mask = '0;
        end
      endcase
    end
  end

  // rs2 moves into the addressed lane, the other lanes stay zero
  always_comb
  begin
    wr_word = '0;
    case (op.kind)
      lsu_pkg::op_sb:
      begin
        wr_word.bytes[offset] = op.store_data[7:0];
      end
      lsu_pkg::op_sh:
      begin
        wr_word.halves[offset[1]] = op.store_data[15:0];
      end
      lsu_pkg::op_sw:
      begin
        wr_word = op.store_data;
      end
      default:
      begin
        wr_word = '0;
      end
    endcase
  end

  assign wr_data = wr_word;

endmodule

/* rtl/lsu_top.sv */
// Load/store unit top level

`timescale 1ns/1ps

module lsu_top (
  input  logic                        clk,
  input  logic                        rst,

  input  logic                        in_valid,
  output logic                        in_ready,
  input  lsu_pkg::word_t              in_pc,
  input  logic [2:0]                  in_funct3,
  input  logic                        in_store,
  input  lsu_pkg::word_t              in_rs1_data,
  input  lsu_pkg::word_t              in_rs2_data,
  input  logic [lsu_pkg::imm_w-1:0]   in_imm,
  input  lsu_pkg::reg_idx_t           in_rd,

  output logic                        bus_req,
  input  logic                        bus_ack,
  output logic                        bus_write,
  output lsu_pkg::word_t              bus_addr,
  output lsu_pkg::lane_mask_t         bus_rd_mask,
  output lsu_pkg::word_t              bus_wr_data,
  output lsu_pkg::lane_mask_t         bus_wr_mask,
  input  lsu_pkg::word_t              bus_rd_data,

  output logic                        out_valid,
  input  logic                        out_ready,
  output logic                        out_trap,
  output logic                        out_rd_wr,
  output lsu_pkg::reg_idx_t           out_rd,
  output lsu_pkg::word_t              out_rd_data,
  output lsu_pkg::word_t              out_pc_next
);

  lsu_pkg::lane_mask_t lane_mask;
  lsu_pkg::word_t      wr_data;
  lsu_pkg::word_t      load_data;

  lsu_op_if op_if ();

  lsu_access_ctrl u_ctrl (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_pc       (in_pc),
    .in_funct3   (in_funct3),
    .in_store    (in_store),
    .in_rs1_data (in_rs1_data),
    .in_rs2_data (in_rs2_data),
    .in_imm      (in_imm),
    .in_rd       (in_rd),
    .bus_req     (bus_req),
    .bus_ack     (bus_ack),
    .bus_write   (bus_write),
    .bus_addr    (bus_addr),
    .bus_rd_mask (bus_rd_mask),
    .bus_wr_mask (bus_wr_mask),
    .bus_wr_data (bus_wr_data),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_trap    (out_trap),
    .out_rd_wr   (out_rd_wr),
    .out_rd      (out_rd),
    .out_rd_data (out_rd_data),
    .out_pc_next (out_pc_next),
    .lane_mask   (lane_mask),
    .wr_data     (wr_data),
    .load_data   (load_data),
    .op          (op_if.ctrl)
  );

  // both lane units work on the held operation in parallel
  lsu_store_lanes u_store_lanes (
    .op        (op_if.lanes),
    .lane_mask (lane_mask),
    .wr_data   (wr_data)
  );

  lsu_load_lanes u_load_lanes (
    .op        (op_if.lanes),
    .rd_word   (bus_rd_data),
    .load_data (load_data)
  );

endmodule

/* verif/lsu_sva.sv */
// Load/store unit handshake assertions

`timescale 1ns/1ps

module lsu_sva (
  input logic                clk,
  input logic                rst,
  input logic                in_ready,
  input logic                bus_req,
  input logic                bus_ack,
  input logic                bus_write,
  input lsu_pkg::word_t      bus_addr,
  input lsu_pkg::lane_mask_t bus_rd_mask,
  input lsu_pkg::lane_mask_t bus_wr_mask,
  input lsu_pkg::word_t      bus_wr_data,
  input logic                out_valid,
  input logic                out_ready,
  input logic                out_trap,
  input logic                out_rd_wr,
  input lsu_pkg::reg_idx_t   out_rd,
  input lsu_pkg::word_t      out_rd_data,
  input lsu_pkg::word_t      out_pc_next
);

  // a pending request keeps every field until the bus acknowledges it
  req_held: assert property (@(posedge clk) disable iff (rst)
    bus_req && !bus_ack |=> bus_req && $stable(bus_addr) && $stable(bus_write)
      && $stable(bus_rd_mask) && $stable(bus_wr_mask) && $stable(bus_wr_data))
    else $error("bus request changed before acknowledge");

  req_drop: assert property (@(posedge clk) disable iff (rst)
    bus_req && bus_ack |=> !bus_req)
    else $error("bus request stayed high after acknowledge");

  // the result is frozen while the consumer stalls
  out_held: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_trap) && $stable(out_rd_wr)
      && $stable(out_rd) && $stable(out_rd_data) && $stable(out_pc_next))
    else $error("result changed before out_ready");

  busy_blocks_input: assert property (@(posedge clk) disable iff (rst)
    bus_req |-> !in_ready)
    else $error("in_ready high during bus request");

  reset_quiet: assert property (@(posedge clk)
    rst |=> !bus_req && !out_valid)
    else $error("bus_req or out_valid high right after reset");

endmodule

bind lsu_top lsu_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .in_ready    (in_ready),
  .bus_req     (bus_req),
  .bus_ack     (bus_ack),
  .bus_write   (bus_write),
  .bus_addr    (bus_addr),
  .bus_rd_mask (bus_rd_mask),
  .bus_wr_mask (bus_wr_mask),
  .bus_wr_data (bus_wr_data),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_trap    (out_trap),
  .out_rd_wr   (out_rd_wr),
  .out_rd      (out_rd),
  .out_rd_data (out_rd_data),
  .out_pc_next (out_pc_next)
);

/* verif/lsu_tb.sv */
// Load/store unit testbench

`timescale 1ns/1ps

module lsu_tb;

  localparam int             wait_limit = 20;
  localparam lsu_pkg::word_t load_word  = 32'h8a7f_c3e1;
  localparam lsu_pkg::word_t store_word = 32'h1122_3344;

  typedef struct packed {
    lsu_pkg::word_t      pc;
    logic [2:0]          funct3;
    logic                store;
    lsu_pkg::word_t      rs1;
    lsu_pkg::word_t      rs2;
    logic [11:0]         imm;
    lsu_pkg::reg_idx_t   rd;
    lsu_pkg::word_t      rd_word;
    lsu_pkg::word_t      exp_addr;
    lsu_pkg::lane_mask_t exp_mask;
    lsu_pkg::word_t      exp_wr_data;
    logic                exp_trap;
    logic                exp_rd_wr;
    lsu_pkg::word_t      exp_rd_data;
  } entry_t;

  logic                clk = 1'b0;
  logic                rst;
  logic                in_valid;
  logic                in_ready;
  lsu_pkg::word_t      in_pc;
  logic [2:0]          in_funct3;
  logic                in_store;
  lsu_pkg::word_t      in_rs1_data;
  lsu_pkg::word_t      in_rs2_data;
  logic [11:0]         in_imm;
  lsu_pkg::reg_idx_t   in_rd;
  logic                bus_req;
  logic                bus_ack;
  logic                bus_write;
  lsu_pkg::word_t      bus_addr;
  lsu_pkg::lane_mask_t bus_rd_mask;
  lsu_pkg::word_t      bus_wr_data;
  lsu_pkg::lane_mask_t bus_wr_mask;
  lsu_pkg::word_t      bus_rd_data;
  logic                out_valid;
  logic                out_ready;
  logic                out_trap;
  logic                out_rd_wr;
  lsu_pkg::reg_idx_t   out_rd;
  lsu_pkg::word_t      out_rd_data;
  lsu_pkg::word_t      out_pc_next;

  entry_t         table_q[$];
  lsu_pkg::word_t resp_word;
  int             seed = 32'h18f38d54;
  int             errors = 0;
  int             checks = 0;
  int             cur_entry = 0;
  logic           timed_out = 1'b0;

  always #2 clk = ~clk;

  lsu_top dut (.*);

  task automatic add_entry(input lsu_pkg::word_t pc, input logic [2:0] funct3,
                           input logic store, input lsu_pkg::word_t rs1,
                           input lsu_pkg::word_t rs2, input logic [11:0] imm,
                           input lsu_pkg::reg_idx_t rd, input lsu_pkg::word_t rd_word,
                           input lsu_pkg::word_t exp_addr, input lsu_pkg::lane_mask_t exp_mask,
                           input lsu_pkg::word_t exp_wr_data, input logic exp_trap,
                           input logic exp_rd_wr, input lsu_pkg::word_t exp_rd_data);
    entry_t e;
    e = '{pc, funct3, store, rs1, rs2, imm, rd, rd_word, exp_addr, exp_mask,
          exp_wr_data, exp_trap, exp_rd_wr, exp_rd_data};
    table_q.push_back(e);
  endtask

  task automatic check_value(input string what, input lsu_pkg::word_t got,
                             input lsu_pkg::word_t exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("** Error at %0t: entry %0d %s is %h, expected %h",
               $time, cur_entry, what, got, exp);
    end
  endtask

  // answers each request after 0 to 3 idle cycles with the current table word
  initial
  begin : responder
    int delay;
    bus_ack     = 1'b0;
    bus_rd_data = '0;
    forever
    begin
      @(posedge clk);
      #1;
      if (bus_req)
      begin
        delay = $random(seed) & 3;
        repeat (delay)
        begin
          @(posedge clk);
          #1;
        end
        bus_rd_data = resp_word;
        bus_ack     = 1'b1;
        @(posedge clk);
        #1;
        bus_ack     = 1'b0;
        bus_rd_data = '0;
      end
    end
  end

  task automatic run_entry(input int idx);
    entry_t              e;
    int                  cnt;
    int                  stall;
    int                  errs_before;
    logic                seen_req;
    logic                got_write;
    lsu_pkg::word_t      got_addr;
    lsu_pkg::word_t      got_wr_data;
    lsu_pkg::lane_mask_t got_rd_mask;
    lsu_pkg::lane_mask_t got_wr_mask;
    e           = table_q[idx];
    cur_entry   = idx;
    errs_before = errors;
    seen_req    = 1'b0;
    cnt = 0;
    while (!in_ready && cnt < wait_limit)
    begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!in_ready)
    begin
      $display("timeout: in_ready never rose before entry %0d", idx);
      timed_out = 1'b1;
      return;
    end
    in_pc       = e.pc;
    in_funct3   = e.funct3;
    in_store    = e.store;
    in_rs1_data = e.rs1;
    in_rs2_data = e.rs2;
    in_imm      = e.imm;
    in_rd       = e.rd;
    resp_word   = e.rd_word;
    stall       = ($random(seed) & 32'h7fff_ffff) % 3;
    in_valid    = 1'b1;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    // watch the bus until the result shows up
    cnt = 0;
    while (!out_valid && cnt < wait_limit)
    begin
      check_value("in_ready while busy", in_ready, 1'b0);
      if (bus_req && !seen_req)
      begin
        seen_req    = 1'b1;
        got_write   = bus_write;
        got_addr    = bus_addr;
        got_rd_mask = bus_rd_mask;
        got_wr_mask = bus_wr_mask;
        got_wr_data = bus_wr_data;
      end
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!out_valid)
    begin
      $display("timeout: no result for entry %0d", idx);
      timed_out = 1'b1;
      return;
    end
    check_value("bus_req seen", seen_req, !e.exp_trap);
    if (seen_req)
    begin
      check_value("bus_write", got_write, e.store);
      check_value("bus_addr", got_addr, e.exp_addr);
      check_value("bus_rd_mask", got_rd_mask, e.store ? 4'b0000 : e.exp_mask);
      check_value("bus_wr_mask", got_wr_mask, e.store ? e.exp_mask : 4'b0000);
      check_value("bus_wr_data", got_wr_data, e.exp_wr_data);
    end
    check_value("out_trap", out_trap, e.exp_trap);
    check_value("out_rd_wr", out_rd_wr, e.exp_rd_wr);
    check_value("out_rd", out_rd, e.rd);
    check_value("out_rd_data", out_rd_data, e.exp_rd_data);
    check_value("out_pc_next", out_pc_next, e.pc + 32'd4);
    repeat (stall)
    begin
      @(posedge clk);
      #1;
      check_value("out_valid during stall", out_valid, 1'b1);
      check_value("in_ready during stall", in_ready, 1'b0);
    end
    out_ready = 1'b1;
    @(posedge clk);
    #1;
    out_ready = 1'b0;
    check_value("in_ready after result", in_ready, 1'b1);
    check_value("out_valid after result", out_valid, 1'b0);
    $display("entry %0d funct3 %0d store %0b: %s", idx, e.funct3, e.store,
             (errors == errs_before) ? "ok" : "mismatch");
  endtask

  initial
  begin : main
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_pc       = '0;
    in_funct3   = '0;
    in_store    = 1'b0;
    in_rs1_data = '0;
    in_rs2_data = '0;
    in_imm      = '0;
    in_rd       = '0;
    out_ready   = 1'b0;
    resp_word   = '0;

    // loads at every offset, bytes e1 c3 7f 8a from lane 0 up
    add_entry(32'h100, 3'd0, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd5, load_word,
              32'h1000, 4'b0001, 32'h0, 1'b0, 1'b1, 32'hffff_ffe1);
    add_entry(32'h104, 3'd4, 1'b0, 32'h1000, 32'h0, 12'h001, 5'd6, load_word,
              32'h1000, 4'b0010, 32'h0, 1'b0, 1'b1, 32'h0000_00c3);
    add_entry(32'h108, 3'd0, 1'b0, 32'h1000, 32'h0, 12'h002, 5'd7, load_word,
              32'h1000, 4'b0100, 32'h0, 1'b0, 1'b1, 32'h0000_007f);
    add_entry(32'h10c, 3'd4, 1'b0, 32'h1000, 32'h0, 12'h003, 5'd8, load_word,
              32'h1000, 4'b1000, 32'h0, 1'b0, 1'b1, 32'h0000_008a);
    add_entry(32'h110, 3'd1, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd9, load_word,
              32'h1000, 4'b0011, 32'h0, 1'b0, 1'b1, 32'hffff_c3e1);
    add_entry(32'h114, 3'd5, 1'b0, 32'h1000, 32'h0, 12'h002, 5'd10, load_word,
              32'h1000, 4'b1100, 32'h0, 1'b0, 1'b1, 32'h0000_8a7f);
    add_entry(32'h118, 3'd2, 1'b0, 32'h2000, 32'h0, 12'h7fc, 5'd11, 32'h0bad_f00d,
              32'h27fc, 4'b1111, 32'h0, 1'b0, 1'b1, 32'h0bad_f00d);
    // imm of -4 lands below rs1
    add_entry(32'h11c, 3'd2, 1'b0, 32'h2000, 32'h0, 12'hffc, 5'd12, 32'h0bad_f00d,
              32'h1ffc, 4'b1111, 32'h0, 1'b0, 1'b1, 32'h0bad_f00d);
    add_entry(32'h120, 3'd0, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd0, load_word,
              32'h1000, 4'b0001, 32'h0, 1'b0, 1'b1, 32'h0);
    // stores, the returned bus word must never reach the result
    add_entry(32'h124, 3'd0, 1'b1, 32'h3000, store_word, 12'h000, 5'd3, load_word,
              32'h3000, 4'b0001, 32'h0000_0044, 1'b0, 1'b0, 32'h0);
    add_entry(32'h128, 3'd0, 1'b1, 32'h3000, store_word, 12'h001, 5'd3, load_word,
              32'h3000, 4'b0010, 32'h0000_4400, 1'b0, 1'b0, 32'h0);
    add_entry(32'h12c, 3'd0, 1'b1, 32'h3000, store_word, 12'h002, 5'd3, load_word,
              32'h3000, 4'b0100, 32'h0044_0000, 1'b0, 1'b0, 32'h0);
    add_entry(32'h130, 3'd0, 1'b1, 32'h3000, store_word, 12'h003, 5'd3, load_word,
              32'h3000, 4'b1000, 32'h4400_0000, 1'b0, 1'b0, 32'h0);
    add_entry(32'h134, 3'd1, 1'b1, 32'h3000, store_word, 12'h000, 5'd3, load_word,
              32'h3000, 4'b0011, 32'h0000_3344, 1'b0, 1'b0, 32'h0);
    add_entry(32'h138, 3'd1, 1'b1, 32'h3004, store_word, 12'hffe, 5'd3, load_word,
              32'h3000, 4'b1100, 32'h3344_0000, 1'b0, 1'b0, 32'h0);
    add_entry(32'h13c, 3'd2, 1'b1, 32'h3000, store_word, 12'h010, 5'd3, load_word,
              32'h3010, 4'b1111, 32'h1122_3344, 1'b0, 1'b0, 32'h0);
    // illegal funct3 and a misaligned PC trap without touching the bus
    add_entry(32'h140, 3'd3, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd4, load_word,
              32'h0, 4'b0000, 32'h0, 1'b1, 1'b0, 32'h0);
    add_entry(32'h144, 3'd6, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd4, load_word,
              32'h0, 4'b0000, 32'h0, 1'b1, 1'b0, 32'h0);
    add_entry(32'h148, 3'd5, 1'b1, 32'h3000, store_word, 12'h000, 5'd4, load_word,
              32'h0, 4'b0000, 32'h0, 1'b1, 1'b0, 32'h0);
    add_entry(32'h202, 3'd2, 1'b0, 32'h1000, 32'h0, 12'h000, 5'd4, load_word,
              32'h0, 4'b0000, 32'h0, 1'b1, 1'b0, 32'h0);

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < table_q.size(); i++)
    begin
      if (!timed_out)
      begin
        run_entry(i);
      end
    end

    $display("entries %0d, checks %0d, errors %0d", table_q.size(), checks, errors);
    if (errors == 0 && !timed_out)
    begin
      $display("*** PASSED ***");
    end
    else
    begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
